// File: rtl/dma_pkg.sv
package dma_pkg;

  ////////////////////////////////////////
  // NoC flit format
  ////////////////////////////////////////

  // Flit position inside a packet, two MSBs of every flit
  typedef enum logic [1:0] {
    MIDDLE = 2'b00,
    FIRST  = 2'b01,
    LAST   = 2'b10,
    SINGLE = 2'b11
  } flit_type_e;

  // One NoC flit as it travels on the link
  typedef struct packed {
    flit_type_e  ftype;
    logic [31:0] content;
  } flit_t;

  ////////////////////////////////////////
  // DMA packet header
  ////////////////////////////////////////

  // Width of the transfer id carried in a header
  localparam int ID_W_MAX = 4;

  // DMA packet kinds
  // Only the two responses are handled on this side
  typedef enum logic [1:0] {
    L2R_REQ  = 2'b00,
    R2L_REQ  = 2'b01,
    L2R_RESP = 2'b10,
    R2L_RESP = 2'b11
  } packet_type_e;

  // Overlay for the content of a header flit, MSB first
  typedef struct packed {
    logic [4:0]          dest;
    logic [2:0]          pclass;
    logic [4:0]          src;
    packet_type_e        ptype;
    // Set on the final packet of a multi-packet response
    logic                resp_last;
    logic [ID_W_MAX-1:0] id;
    logic [11:0]         reserved;
  } header_t;

  ////////////////////////////////////////
  // Wishbone master side
  ////////////////////////////////////////

  // Registered feedback cycle type, classic cycle when idle
  typedef enum logic [2:0] {
    CLASSIC = 3'b000,
    INCR    = 3'b010,
    END     = 3'b111
  } cti_e;

  // All master outputs in one bundle
  typedef struct packed {
    logic [31:0] adr;
    logic [31:0] dat;
    logic [3:0]  sel;
    logic        we;
    logic        cyc;
    logic        stb;
    cti_e        cti;
    logic [1:0]  bte;
  } wb_req_t;

  ////////////////////////////////////////
  // Response handler FSM
  ////////////////////////////////////////

  typedef enum logic [1:0] {
    IDLE,
    GET_SIZE,
    GET_ADDR,
    DATA
  } nocres_state_e;

endpackage

// File: rtl/dma_packet_buffer.sv
module dma_packet_buffer #(
  parameter int FIFO_DEPTH = 16
) (
  input  logic            clk,
  input  logic            rst,

  // Write side from the NoC
  input  dma_pkg::flit_t  in_flit_i,
  input  logic            in_valid_i,
  output logic            in_ready_o,

  // Read side towards the response handler
  output dma_pkg::flit_t  out_flit_o,
  output logic            out_valid_o,
  input  logic            out_ready_i
);

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);
  localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(FIFO_DEPTH - 1);
  localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(FIFO_DEPTH);

  ////////////////////////////////////////
  // Storage and pointers
  ////////////////////////////////////////

  dma_pkg::flit_t   mem [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;

  // Head register holds the flit offered at the read side
  dma_pkg::flit_t   head_flit;
  logic             head_valid;

  logic push;
  logic head_load;

  // Accept while the array has room
  assign in_ready_o = (count != FULL_CNT);
  assign push       = in_valid_i & in_ready_o;

  // Refill the head when it is empty or being taken this cycle
  assign head_load = (count != '0) & (~head_valid | out_ready_i);

  assign out_flit_o  = head_flit;
  assign out_valid_o = head_valid;

  // Array write, payload only
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= in_flit_i;
    end
    if (head_load) begin
      head_flit <= mem[rd_ptr];
    end
  end

  ////////////////////////////////////////
  // Control
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      head_valid <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
      end
      if (head_load) begin
        rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
      end
      // Simultaneous push and refill leave the count as it is
      if (push & ~head_load) begin
        count <= count + 1'b1;
      end else if (~push & head_load) begin
        count <= count - 1'b1;
      end
      if (head_load) begin
        head_valid <= 1'b1;
      end else if (out_ready_i) begin
        head_valid <= 1'b0;
      end
    end
  end

endmodule

// File: rtl/dma_nocres_wb.sv
module dma_nocres_wb #(
  parameter int TABLE_ENTRIES = 4
) (
  input  logic                 clk,
  input  logic                 rst,

  // Response flits from the packet buffer
  input  dma_pkg::flit_t       flit_i,
  input  logic                 flit_valid_i,
  output logic                 flit_ready_o,

  // Wishbone master, write bursts only
  output dma_pkg::wb_req_t     wb_o,
  // Read data is not consumed by a write-only master
  input  logic [31:0]          wb_dat_i,
  input  logic                 wb_ack_i,

  // Completion towards the done table
  output logic                 done_en_o,
  output logic [ID_W-1:0]      done_pos_o
);

  localparam int ID_W = (TABLE_ENTRIES > 1) ? $clog2(TABLE_ENTRIES) : 1;

  ////////////////////////////////////////
  // State and latched header fields
  ////////////////////////////////////////

  dma_pkg::nocres_state_e state_q;
  dma_pkg::nocres_state_e state_d;

  // Burst address, advances by one word per ack
  logic [31:0]     addr_q;
  logic [31:0]     addr_d;
  // Transfer table entry of the response in flight
  logic [ID_W-1:0] id_q;
  logic [ID_W-1:0] id_d;
  // Completion is raised only after the final packet
  logic            last_q;
  logic            last_d;

  dma_pkg::header_t hdr;
  logic             head_flit;
  logic             tail_flit;

  assign hdr = flit_i.content;

  // Headers start a packet, a single flit is header and tail at once
  assign head_flit = (flit_i.ftype == dma_pkg::FIRST) | (flit_i.ftype == dma_pkg::SINGLE);
  assign tail_flit = (flit_i.ftype == dma_pkg::LAST) | (flit_i.ftype == dma_pkg::SINGLE);

  ////////////////////////////////////////
  // Next state and bus outputs
  ////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    addr_d  = addr_q;
    id_d    = id_q;
    last_d  = last_q;

    flit_ready_o = 1'b0;
    done_en_o    = 1'b0;
    done_pos_o   = id_q;

    // Full word writes, linear bursts
    wb_o     = '0;
    wb_o.adr = addr_q;
    wb_o.dat = flit_i.content;
    wb_o.sel = 4'hf;
    wb_o.we  = 1'b1;
    wb_o.cti = dma_pkg::CLASSIC;
    wb_o.bte = 2'b00;

    unique case (state_q)
      dma_pkg::IDLE: begin
        // Pull one flit per cycle, anything not a header is discarded
        flit_ready_o = 1'b1;
        if (flit_valid_i & head_flit) begin
          id_d   = hdr.id[ID_W-1:0];
          last_d = hdr.resp_last;
          if (hdr.ptype == dma_pkg::L2R_RESP) begin
            // Local to remote finished, nothing to write
            done_en_o  = 1'b1;
            done_pos_o = hdr.id[ID_W-1:0];
          end else if (hdr.ptype == dma_pkg::R2L_RESP) begin
            state_d = dma_pkg::GET_SIZE;
          end
        end
      end

      dma_pkg::GET_SIZE: begin
        // Word count is implied by the flit types
        flit_ready_o = 1'b1;
        if (flit_valid_i) begin
          state_d = dma_pkg::GET_ADDR;
        end
      end

      dma_pkg::GET_ADDR: begin
        flit_ready_o = 1'b1;
        if (flit_valid_i) begin
          addr_d  = flit_i.content;
          state_d = dma_pkg::DATA;
        end
      end

      dma_pkg::DATA: begin
        // Beat runs while a data flit waits at the buffer head
        wb_o.cyc = flit_valid_i;
        wb_o.stb = flit_valid_i;
        wb_o.cti = tail_flit ? dma_pkg::END : dma_pkg::INCR;
        if (flit_valid_i & wb_ack_i) begin
          // Buffer pops only when the slave took the word
          flit_ready_o = 1'b1;
          addr_d       = addr_q + 32'd4;
          if (tail_flit) begin
            state_d = dma_pkg::IDLE;
            done_en_o = last_q;
          end
        end
      end

      default: begin
        state_d = dma_pkg::IDLE;
      end
    endcase
  end

  ////////////////////////////////////////
  // Registers
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= dma_pkg::IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Header fields and address
  always_ff @(posedge clk) begin
    addr_q <= addr_d;
    id_q   <= id_d;
    last_q <= last_d;
  end

endmodule

// File: rtl/dma_done_table.sv
module dma_done_table #(
  parameter int TABLE_ENTRIES = 4
) (
  input  logic                     clk,
  input  logic                     rst,

  // Completion from the response handler
  input  logic                     done_en_i,
  input  logic [ID_W-1:0]          done_pos_i,

  // Software acknowledge, one entry per pulse
  input  logic                     clr_en_i,
  input  logic [ID_W-1:0]          clr_pos_i,

  output logic [TABLE_ENTRIES-1:0] done_o
);

  localparam int ID_W = (TABLE_ENTRIES > 1) ? $clog2(TABLE_ENTRIES) : 1;

  ////////////////////////////////////////
  // Set and clear masks
  ////////////////////////////////////////

  logic [TABLE_ENTRIES-1:0] done_q;
  logic [TABLE_ENTRIES-1:0] set_mask;
  logic [TABLE_ENTRIES-1:0] clr_mask;

  // One-hot decode of both positions
  always_comb begin
    set_mask = '0;
    clr_mask = '0;
    for (int i = 0; i < TABLE_ENTRIES; i++) begin
      set_mask[i] = done_en_i & (done_pos_i == ID_W'(i));
      clr_mask[i] = clr_en_i & (clr_pos_i == ID_W'(i));
    end
  end

  ////////////////////////////////////////
  // Sticky status
  ////////////////////////////////////////

  // Set is applied after the clear so it wins on a collision
  always_ff @(posedge clk) begin
    if (rst) begin
      done_q <= '0;
    end else begin
      done_q <= (done_q & ~clr_mask) | set_mask;
    end
  end

  assign done_o = done_q;

endmodule

// File: rtl/dma_resp_top.sv
module dma_resp_top #(
  parameter int TABLE_ENTRIES = 4,
  parameter int FIFO_DEPTH    = 16
) (
  input  logic                     clk,
  input  logic                     rst,

  // NoC response input
  input  dma_pkg::flit_t           flit_i,
  input  logic                     flit_valid_i,
  output logic                     flit_ready_o,

  // Local memory
  output dma_pkg::wb_req_t         wb_o,
  input  logic [31:0]              wb_dat_i,
  input  logic                     wb_ack_i,

  // Completion status
  input  logic                     clr_en_i,
  input  logic [ID_W-1:0]          clr_pos_i,
  output logic [TABLE_ENTRIES-1:0] done_o
);

  localparam int ID_W = (TABLE_ENTRIES > 1) ? $clog2(TABLE_ENTRIES) : 1;

  ////////////////////////////////////////
  // Internal links
  ////////////////////////////////////////

  // Buffer head towards the handler
  dma_pkg::flit_t  buf_flit;
  logic            buf_valid;
  logic            buf_ready;

  // Completion pulse
  logic            done_en;
  logic [ID_W-1:0] done_pos;

  // Full buffer stalls the NoC when the memory holds off ack
  dma_packet_buffer #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_buffer (
    .clk         (clk),
    .rst         (rst),
    .in_flit_i   (flit_i),
    .in_valid_i  (flit_valid_i),
    .in_ready_o  (flit_ready_o),
    .out_flit_o  (buf_flit),
    .out_valid_o (buf_valid),
    .out_ready_i (buf_ready)
  );

  dma_nocres_wb #(
    .TABLE_ENTRIES (TABLE_ENTRIES)
  ) u_handler (
    .clk          (clk),
    .rst          (rst),
    .flit_i       (buf_flit),
    .flit_valid_i (buf_valid),
    .flit_ready_o (buf_ready),
    .wb_o         (wb_o),
    .wb_dat_i     (wb_dat_i),
    .wb_ack_i     (wb_ack_i),
    .done_en_o    (done_en),
    .done_pos_o   (done_pos)
  );

  dma_done_table #(
    .TABLE_ENTRIES (TABLE_ENTRIES)
  ) u_done_table (
    .clk        (clk),
    .rst        (rst),
    .done_en_i  (done_en),
    .done_pos_i (done_pos),
    .clr_en_i   (clr_en_i),
    .clr_pos_i  (clr_pos_i),
    .done_o     (done_o)
  );

endmodule

// File: verif/dma_resp_asserts.sv
module dma_resp_asserts (
  input logic                   clk,
  input logic                   rst,
  input dma_pkg::nocres_state_e state_i,
  input dma_pkg::wb_req_t       wb_i,
  input logic                   wb_ack_i,
  input logic                   done_en_i
);

  timeunit 1ns;
  timeprecision 1ps;

  ////////////////////////////////////////
  // Wishbone master rules
  ////////////////////////////////////////

  // A beat waits for ack with address and data frozen
  property stb_held_p;
    @(posedge clk) disable iff (rst)
      (wb_i.stb & ~wb_ack_i) |=> (wb_i.stb & $stable(wb_i.adr) & $stable(wb_i.dat));
  endproperty

  // Completion of an R2L burst only together with the final ack
  property no_done_without_ack_p;
    @(posedge clk) disable iff (rst)
      ((state_i == dma_pkg::DATA) & ~wb_ack_i) |-> ~done_en_i;
  endproperty

  // Bus is released by reset
  property cyc_low_after_reset_p;
    @(posedge clk) rst |=> ~wb_i.cyc;
  endproperty

  stb_held_a: assert property (stb_held_p)
    else $error("stb dropped or request changed before ack");
  no_done_without_ack_a: assert property (no_done_without_ack_p)
    else $error("done_en raised during a DATA beat without ack");
  cyc_low_after_reset_a: assert property (cyc_low_after_reset_p)
    else $error("cyc high right after reset");

endmodule

bind dma_nocres_wb dma_resp_asserts u_asserts (
  .clk       (clk),
  .rst       (rst),
  .state_i   (state_q),
  .wb_i      (wb_o),
  .wb_ack_i  (wb_ack_i),
  .done_en_i (done_en_o)
);

// File: verif/tb_dma_resp.sv
module tb_dma_resp;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int TABLE_ENTRIES = 4;
  localparam int FIFO_DEPTH    = 16;
  localparam int ID_W          = 2;
  localparam int TIMEOUT       = 1000;
  localparam int NUM_PKTS      = 5;

  // One response packet and the done vector expected after it
  typedef struct packed {
    dma_pkg::packet_type_e    ptype;
    logic [ID_W-1:0]          id;
    logic                     resp_last;
    logic [31:0]              base;
    logic [7:0]               words;
    logic [31:0]              seed;
    logic [TABLE_ENTRIES-1:0] exp_done;
    // Hold ack until the buffer fills
    logic                     stall;
  } pkt_t;

  localparam pkt_t PKTS [NUM_PKTS] = '{
    '{dma_pkg::L2R_RESP, 2'd1, 1'b1, 32'h0000_0000, 8'd0, 32'h0000_0000, 4'b0010, 1'b0},
    '{dma_pkg::R2L_RESP, 2'd2, 1'b1, 32'h0000_1000, 8'd4, 32'h3ac5_058b, 4'b0110, 1'b0},
    '{dma_pkg::R2L_RESP, 2'd0, 1'b0, 32'h0000_2000, 8'd3, 32'h3ac5_158b, 4'b0110, 1'b0},
    '{dma_pkg::R2L_RESP, 2'd0, 1'b1, 32'h0000_2100, 8'd5, 32'h3ac5_258b, 4'b0111, 1'b0},
    '{dma_pkg::R2L_RESP, 2'd3, 1'b1, 32'h0000_3000, 8'd20, 32'h3ac5_358b, 4'b1111, 1'b1}
  };

  logic                     clk;
  logic                     rst;
  dma_pkg::flit_t           flit_i;
  logic                     flit_valid_i;
  logic                     flit_ready_o;
  dma_pkg::wb_req_t         wb_o;
  logic [31:0]              wb_dat_i;
  logic                     wb_ack_i;
  logic                     clr_en_i;
  logic [ID_W-1:0]          clr_pos_i;
  logic [TABLE_ENTRIES-1:0] done_o;

  // Memory model state
  logic [31:0]    mem_words [logic [31:0]];
  dma_pkg::cti_e  cti_log [$];
  logic [31:0]    exp_words [$];
  int             delay_seed = 32'h3ac5_058b;
  int             ack_wait   = 0;
  int             beat_count = 0;
  logic           beat_armed = 1'b0;
  logic           ack_hold   = 1'b0;
  logic           cyc_seen   = 1'b0;

  dma_resp_top #(
    .TABLE_ENTRIES (TABLE_ENTRIES),
    .FIFO_DEPTH    (FIFO_DEPTH)
  ) DUT (
    .clk          (clk),
    .rst          (rst),
    .flit_i       (flit_i),
    .flit_valid_i (flit_valid_i),
    .flit_ready_o (flit_ready_o),
    .wb_o         (wb_o),
    .wb_dat_i     (wb_dat_i),
    .wb_ack_i     (wb_ack_i),
    .clr_en_i     (clr_en_i),
    .clr_pos_i    (clr_pos_i),
    .done_o       (done_o)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  ////////////////////////////////////////
  // Wishbone memory model
  ////////////////////////////////////////

  // Acks after 0 to 5 cycles, the word is logged as ack goes up
  always @(negedge clk) begin
    wb_ack_i = 1'b0;
    if (rst) begin
      beat_armed = 1'b0;
    end else if (wb_o.cyc & wb_o.stb & ~ack_hold) begin
      cyc_seen = 1'b1;
      if (!beat_armed) begin
        ack_wait   = $unsigned($random(delay_seed)) % 6;
        beat_armed = 1'b1;
      end
      if (ack_wait == 0) begin
        check_write_req(wb_o, beat_count);
        wb_ack_i   = 1'b1;
        beat_armed = 1'b0;
        mem_words[wb_o.adr] = wb_o.dat;
        cti_log.push_back(wb_o.cti);
        beat_count++;
      end else begin
        ack_wait--;
      end
    end else if (wb_o.cyc) begin
      cyc_seen = 1'b1;
    end
  end

  ////////////////////////////////////////
  // Failure and compare tasks
  ////////////////////////////////////////

  task automatic stop_run(input string line);
    $display("%s", line);
    $display(">>> FAIL");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_word(input logic [31:0] got, input logic [31:0] exp, input int idx);
    if (got !== exp) begin
      stop_run($sformatf("ERROR at %0t ns: word %0d is %h, expected %h", $time, idx, got, exp));
    end
  endtask

  task automatic check_done(input logic [TABLE_ENTRIES-1:0] got,
                            input logic [TABLE_ENTRIES-1:0] exp, input string what);
    if (got !== exp) begin
      stop_run($sformatf("ERROR at %0t ns: done_o %b, expected %b (%s)", $time, got, exp, what));
    end
  endtask

  task automatic check_cti(input dma_pkg::cti_e got, input dma_pkg::cti_e exp, input int beat);
    if (got !== exp) begin
      stop_run($sformatf("ERROR at %0t ns: beat %0d cti %s, expected %s",
                         $time, beat, got.name(), exp.name()));
    end
  endtask

  // Every beat is a full-word write in a linear burst
  task automatic check_write_req(input dma_pkg::wb_req_t got, input int beat);
    if (got.we !== 1'b1 || got.sel !== 4'hf || got.bte !== 2'b00) begin
      stop_run($sformatf("ERROR at %0t ns: beat %0d we %b sel %h bte %b, expected 1, f, 0",
                         $time, beat, got.we, got.sel, got.bte));
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      stop_run($sformatf("ERROR at %0t ns: %s is %b, expected %b", $time, what, got, exp));
    end
  endtask

  ////////////////////////////////////////
  // Flit driver and waits
  ////////////////////////////////////////

  // Called on a falling edge, returns on the falling edge after the transfer
  task automatic send_flit(input dma_pkg::flit_type_e ftype, input logic [31:0] content);
    int waited;
    waited = 0;
    flit_i.ftype   = ftype;
    flit_i.content = content;
    flit_valid_i   = 1'b1;
    while (!flit_ready_o) begin
      @(negedge clk);
      waited++;
      if (waited > TIMEOUT) stop_run("Timed out waiting for flit_ready_o to accept a flit");
    end
    @(negedge clk);
  endtask

  task automatic send_r2l_flits(input dma_pkg::header_t hdr, input pkt_t pkt);
    dma_pkg::flit_type_e ftype;
    send_flit(dma_pkg::FIRST, hdr);
    send_flit(dma_pkg::MIDDLE, 32'(pkt.words));
    send_flit(dma_pkg::MIDDLE, pkt.base);
    for (int i = 0; i < pkt.words; i++) begin
      ftype = (i == pkt.words - 1) ? dma_pkg::LAST : dma_pkg::MIDDLE;
      send_flit(ftype, exp_words[i]);
    end
    flit_valid_i = 1'b0;
  endtask

  // Lets ack through once the full buffer pushes back on the NoC side
  task automatic release_hold_when_full();
    int waited;
    waited = 0;
    while (flit_ready_o) begin
      @(negedge clk);
      waited++;
      if (waited > TIMEOUT) stop_run("flit_ready_o never dropped while ack was held");
    end
    repeat (3) @(posedge clk);
    ack_hold = 1'b0;
  endtask

  task automatic wait_beats(input int target);
    int waited;
    waited = 0;
    while (beat_count < target) begin
      @(posedge clk);
      waited++;
      if (waited > TIMEOUT) stop_run("Timed out waiting for the Wishbone write acks");
    end
    // Done table updates on the edge of the final ack
    @(negedge clk);
  endtask

  task automatic wait_done_bit(input int k);
    int waited;
    waited = 0;
    while (!done_o[k]) begin
      @(negedge clk);
      waited++;
      if (waited > TIMEOUT) stop_run("Timed out waiting for the L2R completion");
    end
  endtask

  ////////////////////////////////////////
  // Packet sequence
  ////////////////////////////////////////

  task automatic run_packet(input pkt_t pkt);
    dma_pkg::header_t hdr;
    int               data_seed;
    int               beats_start;
    logic [31:0]      addr;
    hdr           = '0;
    hdr.ptype     = pkt.ptype;
    hdr.resp_last = pkt.resp_last;
    hdr.id        = pkt.id;
    data_seed     = pkt.seed;
    beats_start   = beat_count;
    cyc_seen      = 1'b0;
    cti_log.delete();
    exp_words.delete();
    if (pkt.ptype == dma_pkg::L2R_RESP) begin
      send_flit(dma_pkg::SINGLE, hdr);
      flit_valid_i = 1'b0;
      wait_done_bit(pkt.id);
      check_flag(cyc_seen, 1'b0, "Wishbone cycle seen for an L2R response");
    end else begin
      for (int i = 0; i < pkt.words; i++) begin
        exp_words.push_back($random(data_seed));
      end
      ack_hold = pkt.stall;
      fork
        send_r2l_flits(hdr, pkt);
        if (pkt.stall) release_hold_when_full();
      join
      wait_beats(beats_start + pkt.words);
      if (cti_log.size() != pkt.words) stop_run("Wrong number of Wishbone beats for a burst");
      for (int i = 0; i < pkt.words; i++) begin
        // Word i lands at base plus four bytes per word
        addr = pkt.base + 32'(4 * i);
        if (!mem_words.exists(addr)) stop_run("A data word never reached its memory address");
        check_word(mem_words[addr], exp_words[i], i);
        check_cti(cti_log[i], (i == pkt.words - 1) ? dma_pkg::END : dma_pkg::INCR, i);
      end
    end
  endtask

  task automatic clear_entry(input logic [ID_W-1:0] k);
    clr_en_i  = 1'b1;
    clr_pos_i = k;
    @(negedge clk);
    clr_en_i  = 1'b0;
  endtask

  initial begin
    rst          = 1'b1;
    flit_i       = '0;
    flit_valid_i = 1'b0;
    wb_dat_i     = '0;
    wb_ack_i     = 1'b0;
    clr_en_i     = 1'b0;
    clr_pos_i    = '0;
    repeat (10) @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    check_done(done_o, '0, "after reset");
    check_flag(wb_o.cyc, 1'b0, "cyc after reset");
    check_flag(flit_ready_o, 1'b1, "flit_ready_o after reset");
    for (int p = 0; p < NUM_PKTS; p++) begin
      run_packet(PKTS[p]);
      check_done(done_o, PKTS[p].exp_done, $sformatf("packet %0d", p));
    end
    // Single-entry clears keep the other bits
    clear_entry(2'd2);
    check_done(done_o, 4'b1011, "clear of entry 2");
    clear_entry(2'd0);
    check_done(done_o, 4'b1010, "clear of entry 0");
    $display(">>> PASS");
    $finish;
  end

endmodule

// File: tb.f
rtl/dma_pkg.sv
rtl/dma_packet_buffer.sv
rtl/dma_nocres_wb.sv
rtl/dma_done_table.sv
rtl/dma_resp_top.sv
verif/dma_resp_asserts.sv
verif/tb_dma_resp.sv

// File: Bender.yml
package:
  name: dma_resp

sources:
  # Design, package first
  - files:
      - rtl/dma_pkg.sv
      - rtl/dma_packet_buffer.sv
      - rtl/dma_nocres_wb.sv
      - rtl/dma_done_table.sv
      - rtl/dma_resp_top.sv

  # Testbench and bound assertions
  - target: test
    files:
      - verif/dma_resp_asserts.sv
      - verif/tb_dma_resp.sv
